// File: nec_ir_receiver.f
src/nec_ir_pkg.sv
src/tick_prescaler.sv
src/ir_input_conditioner.sv
src/edge_timer.sv
src/nec_frame_decoder.sv
src/frame_fifo.sv
src/wb_ir_registers.sv
src/nec_ir_receiver.sv
verification/nec_ir_receiver_checker.sv
verification/nec_ir_receiver_tb.sv

// File: src/edge_timer.sv
// Level change detector measuring the duration of the previous IR level
`timescale 1ns/1ps

module edge_timer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear_n_i,
  input  logic                         sample_value_i,
  input  logic                         sample_valid_i,
  output logic                         edge_strobe_o,
  output logic                         edge_rising_o,
  output logic [nec_ir_pkg::dsize-1:0] edge_delay_o,
  output logic                         edge_timeout_o
);

  logic                         last_value;
  logic [nec_ir_pkg::dsize-1:0] cnt;
  logic                         change;
  logic                         saturated;

  assign change    = sample_valid_i && (sample_value_i != last_value);
  assign saturated = &cnt;

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      last_value    <= 1'b0;
      cnt           <= '1;  // Start saturated so the first edge is a timeout
      edge_strobe_o <= 1'b0;
    end else begin
      edge_strobe_o <= change;
      if (sample_valid_i) begin
        last_value <= sample_value_i;
        if (change) begin
          cnt <= nec_ir_pkg::reload_offset;
        end else if (!saturated) begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Edge report payload
  always_ff @(posedge clk) begin
    if (change) begin
      edge_rising_o  <= sample_value_i;             // New level
      edge_delay_o   <= saturated ? cnt : cnt + 1'b1;
      edge_timeout_o <= saturated;
    end
  end

endmodule

// File: src/frame_fifo.sv
// Four-entry FIFO of decoded address and data pairs
`timescale 1ns/1ps

module frame_fifo (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              clear_n_i,
  input  logic [nec_ir_pkg::fifo_width-1:0] wr_data_i,
  input  logic                              wr_en_i,
  output logic                              full_o,
  output logic [nec_ir_pkg::fifo_width-1:0] rd_data_o,
  input  logic                              rd_en_i,
  output logic                              not_empty_o
);

  logic [nec_ir_pkg::fifo_width-1:0]    mem [nec_ir_pkg::fifo_depth];
  logic [nec_ir_pkg::fifo_depth_log2-1:0] wr_ptr;
  logic [nec_ir_pkg::fifo_depth_log2-1:0] rd_ptr;
  logic [nec_ir_pkg::fifo_depth_log2:0]   count;
  logic                                   push;
  logic                                   pop;

  assign full_o      = count[nec_ir_pkg::fifo_depth_log2];  // Count equals depth
  assign not_empty_o = (count != '0);
  assign push        = wr_en_i && !full_o;   // Frame dropped when full
  assign pop         = rd_en_i && not_empty_o;
  assign rd_data_o   = mem[rd_ptr];          // Oldest entry

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

endmodule

// File: src/ir_input_conditioner.sv
// IR input synchronizer, polarity inversion and three-sample majority filter
`timescale 1ns/1ps

module ir_input_conditioner (
  input  logic clk,
  input  logic rst_n,
  input  logic clear_n_i,
  input  logic polarity_i,
  input  logic ir_i,
  input  logic tick_i,
  output logic sample_value_o,
  output logic sample_valid_o
);

  logic [nec_ir_pkg::sync_stages-1:0] sync_q;
  logic                               ir_level;
  logic [2:0]                         window;

  ////////////////////////////////////////
  // Synchronizer chain
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[nec_ir_pkg::sync_stages-2:0], ir_i};
    end
  end

  assign ir_level = sync_q[nec_ir_pkg::sync_stages-1] ^ polarity_i;  // Invert if set

  ////////////////////////////////////////
  // Majority window
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      window         <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= tick_i;
      if (tick_i) begin
        window <= {window[1:0], ir_level};
      end
    end
  end

  // Two out of three
  assign sample_value_o = (window[0] & window[1]) |
                          (window[1] & window[2]) |
                          (window[2] & window[0]);

endmodule

// File: src/nec_frame_decoder.sv
// NEC frame decoder FSM with leader, data bit, stop and complement checks
`timescale 1ns/1ps

module nec_frame_decoder (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear_n_i,
  input  logic                         edge_strobe_i,
  input  logic                         edge_rising_i,
  input  logic [nec_ir_pkg::dsize-1:0] edge_delay_i,
  input  logic                         edge_timeout_i,
  output logic [7:0]                   frame_addr_o,
  output logic [7:0]                   frame_data_o,
  output logic                         frame_write_o
);

  nec_ir_pkg::decoder_state_e   state;
  logic [31:0]                  shift_q;  // LSB first with marker bit
  logic [nec_ir_pkg::dsize-1:0] masked;
  logic                         fall_ok;
  logic                         rise_ok;
  logic                         leader_mark;
  logic                         leader_space;
  logic                         bit_mark;
  logic                         bit_zero;
  logic                         bit_one;
  logic                         addr_ok;
  logic                         data_ok;

  assign masked  = edge_delay_i & nec_ir_pkg::delay_mask;
  assign fall_ok = edge_strobe_i && !edge_timeout_i && !edge_rising_i;
  assign rise_ok = edge_strobe_i && !edge_timeout_i && edge_rising_i;

  assign leader_mark  = fall_ok && (masked == nec_ir_pkg::leader_mark_units);
  assign leader_space = rise_ok && (masked == nec_ir_pkg::leader_space_units);
  assign bit_mark     = fall_ok && (masked == nec_ir_pkg::bit_mark_units);
  assign bit_zero     = rise_ok && (masked == nec_ir_pkg::zero_space_units);
  assign bit_one      = rise_ok && (masked == nec_ir_pkg::one_space_units);

  assign addr_ok = (shift_q[7:0] == ~shift_q[15:8]);
  assign data_ok = (shift_q[23:16] == ~shift_q[31:24]);

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      state         <= nec_ir_pkg::idle_st;
      frame_write_o <= 1'b0;
    end else begin
      frame_write_o <= (state == nec_ir_pkg::stop_st) && bit_mark && addr_ok && data_ok;
      if (edge_strobe_i) begin
        case (state)
          nec_ir_pkg::idle_st:
            if (leader_mark) state <= nec_ir_pkg::leader_st;
          nec_ir_pkg::leader_st:
            state <= leader_space ? nec_ir_pkg::bit_mark_st : nec_ir_pkg::idle_st;
          nec_ir_pkg::bit_mark_st:
            state <= bit_mark ? nec_ir_pkg::bit_space_st : nec_ir_pkg::idle_st;
          nec_ir_pkg::bit_space_st:
            if (!(bit_zero || bit_one)) begin
              state <= nec_ir_pkg::idle_st;
            end else if (shift_q[0]) begin
              state <= nec_ir_pkg::stop_st;        // Marker reached, 32 bits in
            end else begin
              state <= nec_ir_pkg::bit_mark_st;
            end
          default:
            state <= nec_ir_pkg::idle_st;          // Stop mark ends the frame
        endcase
      end
    end
  end

  // Shift register and frame payload
  always_ff @(posedge clk) begin
    if (state == nec_ir_pkg::leader_st && leader_space) begin
      shift_q <= 32'h8000_0000;
    end else if (state == nec_ir_pkg::bit_space_st && (bit_zero || bit_one)) begin
      shift_q <= {bit_one, shift_q[31:1]};
    end
    if (state == nec_ir_pkg::stop_st && edge_strobe_i) begin
      frame_addr_o <= shift_q[7:0];
      frame_data_o <= shift_q[23:16];
    end
  end

endmodule

// File: src/nec_ir_pkg.sv
// Shared widths, NEC pulse constants, register map and decoder state encoding
package nec_ir_pkg;

  localparam int sync_stages = 3;   // IR input synchronizer depth
  localparam int psize       = 16;  // Prescaler ratio and accumulator width
  localparam int dsize       = 11;  // Edge timer width

  ////////////////////////////////////////
  // NEC pulse lengths in ticks
  ////////////////////////////////////////
  localparam logic [dsize-1:0] reload_offset      = 11'd2;
  localparam logic [dsize-1:0] delay_mask         = 11'h7fc;  // Drops two LSBs
  localparam logic [dsize-1:0] leader_mark_units  = 11'd128;  // 9 ms
  localparam logic [dsize-1:0] leader_space_units = 11'd64;   // 4.5 ms
  localparam logic [dsize-1:0] bit_mark_units     = 11'd8;    // Also the stop mark
  localparam logic [dsize-1:0] zero_space_units   = 11'd8;
  localparam logic [dsize-1:0] one_space_units    = 11'd24;

  localparam int fifo_depth_log2 = 2;
  localparam int fifo_depth      = 1 << fifo_depth_log2;
  localparam int fifo_width      = 16;  // {address, data}

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////
  typedef enum logic [1:0] {
    ctrl_reg   = 2'd0,
    mult_reg   = 2'd1,
    div_reg    = 2'd2,
    status_reg = 2'd3
  } reg_addr_e;

  localparam int ctrl_en_bit      = 31;
  localparam int ctrl_irq_en_bit  = 29;
  localparam int ctrl_pol_bit     = 28;
  localparam int status_avail_bit = 31;
  localparam int status_lost_bit  = 29;

  typedef enum logic [2:0] {
    idle_st, leader_st, bit_mark_st, bit_space_st, stop_st
  } decoder_state_e;

endpackage

// File: src/nec_ir_receiver.sv
// NEC infrared receiver top level with Wishbone slave port
`timescale 1ns/1ps

module nec_ir_receiver (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wbs_cyc_i,
  input  logic        wbs_stb_i,
  input  logic        wbs_we_i,
  input  logic [31:0] wbs_adr_i,
  input  logic [31:0] wbs_dat_i,
  output logic [31:0] wbs_dat_o,
  output logic        wbs_ack_o,
  input  logic        ir_i,
  output logic        irq_o
);

  logic                             receiver_en;
  logic                             polarity;
  logic [nec_ir_pkg::psize-1:0]     multiplier;
  logic [nec_ir_pkg::psize-1:0]     divider;
  logic                             tick;
  logic                             sample_value;
  logic                             sample_valid;
  logic                             edge_strobe;
  logic                             edge_rising;
  logic [nec_ir_pkg::dsize-1:0]     edge_delay;
  logic                             edge_timeout;
  logic [7:0]                       frame_addr;
  logic [7:0]                       frame_data;
  logic                             frame_write;
  logic                             frame_read;
  logic                             fifo_full;
  logic                             fifo_not_empty;
  logic [nec_ir_pkg::fifo_width-1:0] fifo_data;

  tick_prescaler u_prescaler (
    .clk, .rst_n,
    .clear_n_i    (receiver_en),
    .multiplier_i (multiplier),
    .divider_i    (divider),
    .tick_o       (tick)
  );

  ir_input_conditioner u_conditioner (
    .clk, .rst_n,
    .clear_n_i      (receiver_en),
    .polarity_i     (polarity),
    .ir_i           (ir_i),
    .tick_i         (tick),
    .sample_value_o (sample_value),
    .sample_valid_o (sample_valid)
  );

  edge_timer u_edge_timer (
    .clk, .rst_n,
    .clear_n_i      (receiver_en),
    .sample_value_i (sample_value),
    .sample_valid_i (sample_valid),
    .edge_strobe_o  (edge_strobe),
    .edge_rising_o  (edge_rising),
    .edge_delay_o   (edge_delay),
    .edge_timeout_o (edge_timeout)
  );

  nec_frame_decoder u_decoder (
    .clk, .rst_n,
    .clear_n_i      (receiver_en),
    .edge_strobe_i  (edge_strobe),
    .edge_rising_i  (edge_rising),
    .edge_delay_i   (edge_delay),
    .edge_timeout_i (edge_timeout),
    .frame_addr_o   (frame_addr),
    .frame_data_o   (frame_data),
    .frame_write_o  (frame_write)
  );

  frame_fifo u_fifo (
    .clk, .rst_n,
    .clear_n_i   (receiver_en),
    .wr_data_i   ({frame_addr, frame_data}),
    .wr_en_i     (frame_write),
    .full_o      (fifo_full),
    .rd_data_o   (fifo_data),
    .rd_en_i     (frame_read),
    .not_empty_o (fifo_not_empty)
  );

  wb_ir_registers u_registers (
    .clk, .rst_n,
    .wbs_cyc_i, .wbs_stb_i, .wbs_we_i, .wbs_adr_i, .wbs_dat_i, .wbs_dat_o, .wbs_ack_o,
    .frame_write_i    (frame_write),
    .fifo_full_i      (fifo_full),
    .fifo_not_empty_i (fifo_not_empty),
    .fifo_data_i      (fifo_data),
    .frame_read_o     (frame_read),
    .receiver_en_o    (receiver_en),
    .polarity_o       (polarity),
    .multiplier_o     (multiplier),
    .divider_o        (divider),
    .irq_o            (irq_o)
  );

endmodule

// File: src/tick_prescaler.sv
// Fractional prescaler producing sample ticks at multiplier/divider of the clock
`timescale 1ns/1ps

module tick_prescaler (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear_n_i,
  input  logic [nec_ir_pkg::psize-1:0] multiplier_i,
  input  logic [nec_ir_pkg::psize-1:0] divider_i,
  output logic                         tick_o
);

  logic [nec_ir_pkg::psize-1:0] acc;
  logic [nec_ir_pkg::psize:0]   sum;   // One spare bit against overflow
  logic [nec_ir_pkg::psize:0]   wrapped;

  assign sum     = {1'b0, acc} + {1'b0, multiplier_i};
  assign wrapped = sum - {1'b0, divider_i};

  always_ff @(posedge clk) begin
    if (!rst_n || !clear_n_i) begin
      acc    <= '0;
      tick_o <= 1'b0;
    end else if (sum > {1'b0, divider_i}) begin
      acc    <= wrapped[nec_ir_pkg::psize-1:0];  // Keep the remainder
      tick_o <= 1'b1;
    end else begin
      acc    <= sum[nec_ir_pkg::psize-1:0];
      tick_o <= 1'b0;
    end
  end

endmodule

// File: src/wb_ir_registers.sv
// Wishbone register block for control, prescaler ratio, status, lost flag and irq
`timescale 1ns/1ps

module wb_ir_registers (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wbs_cyc_i,
  input  logic                              wbs_stb_i,
  input  logic                              wbs_we_i,
  input  logic [31:0]                       wbs_adr_i,
  input  logic [31:0]                       wbs_dat_i,
  output logic [31:0]                       wbs_dat_o,
  output logic                              wbs_ack_o,
  input  logic                              frame_write_i,
  input  logic                              fifo_full_i,
  input  logic                              fifo_not_empty_i,
  input  logic [nec_ir_pkg::fifo_width-1:0] fifo_data_i,
  output logic                              frame_read_o,
  output logic                              receiver_en_o,
  output logic                              polarity_o,
  output logic [nec_ir_pkg::psize-1:0]      multiplier_o,
  output logic [nec_ir_pkg::psize-1:0]      divider_o,
  output logic                              irq_o
);

  nec_ir_pkg::reg_addr_e addr;
  logic                  req;
  logic                  status_rd;
  logic                  irq_en;
  logic                  lost;

  assign req       = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;  // One request at a time
  assign addr      = nec_ir_pkg::reg_addr_e'(wbs_adr_i[3:2]);
  assign status_rd = req && !wbs_we_i && (addr == nec_ir_pkg::status_reg);

  ////////////////////////////////////////
  // Control state and writes
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wbs_ack_o     <= 1'b0;
      frame_read_o  <= 1'b0;
      irq_o         <= 1'b0;
      lost          <= 1'b0;
      receiver_en_o <= 1'b0;
      irq_en        <= 1'b0;
      polarity_o    <= 1'b0;
      multiplier_o  <= '0;
      divider_o     <= '0;
    end else begin
      wbs_ack_o    <= req;
      frame_read_o <= status_rd;                  // Pop after the sampled read
      irq_o        <= irq_en && frame_write_i;
      if (frame_write_i && fifo_full_i) begin
        lost <= 1'b1;                             // Set wins over clear
      end else if (status_rd) begin
        lost <= 1'b0;
      end
      if (req && wbs_we_i) begin
        case (addr)
          nec_ir_pkg::ctrl_reg: begin
            receiver_en_o <= wbs_dat_i[nec_ir_pkg::ctrl_en_bit];
            irq_en        <= wbs_dat_i[nec_ir_pkg::ctrl_irq_en_bit];
            polarity_o    <= wbs_dat_i[nec_ir_pkg::ctrl_pol_bit];
          end
          nec_ir_pkg::mult_reg: multiplier_o <= wbs_dat_i[nec_ir_pkg::psize-1:0];
          nec_ir_pkg::div_reg:  divider_o    <= wbs_dat_i[nec_ir_pkg::psize-1:0];
          default: ;                              // Status is read-only
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (req) begin
      wbs_dat_o <= '0;
      case (addr)
        nec_ir_pkg::ctrl_reg: begin
          wbs_dat_o[nec_ir_pkg::ctrl_en_bit]     <= receiver_en_o;
          wbs_dat_o[nec_ir_pkg::ctrl_irq_en_bit] <= irq_en;
          wbs_dat_o[nec_ir_pkg::ctrl_pol_bit]    <= polarity_o;
        end
        nec_ir_pkg::mult_reg: wbs_dat_o[nec_ir_pkg::psize-1:0] <= multiplier_o;
        nec_ir_pkg::div_reg:  wbs_dat_o[nec_ir_pkg::psize-1:0] <= divider_o;
        nec_ir_pkg::status_reg: begin
          wbs_dat_o[nec_ir_pkg::status_avail_bit] <= fifo_not_empty_i;
          wbs_dat_o[nec_ir_pkg::status_lost_bit]  <= lost;
          wbs_dat_o[nec_ir_pkg::fifo_width-1:0]   <= fifo_data_i;  // Address and data
        end
        default: ;
      endcase
    end
  end

endmodule

// File: verification/nec_ir_receiver_checker.sv
// Concurrent assertions on Wishbone acknowledge, interrupt pulse and FIFO pop
`timescale 1ns/1ps

module nec_ir_receiver_checker (
  input logic clk,
  input logic rst_n,
  input logic wbs_cyc_i,
  input logic wbs_stb_i,
  input logic wbs_ack_i,
  input logic irq_i,
  input logic frame_read_i
);

  logic req;

  assign req = wbs_cyc_i && wbs_stb_i && !wbs_ack_i;  // New request this cycle

  ////////////////////////////////////////
  // Bus acknowledge
  ////////////////////////////////////////
  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    req |=> wbs_ack_i ##1 !wbs_ack_i)
    else $error("ack did not follow the request for exactly one cycle");

  ////////////////////////////////////////
  // Interrupt and FIFO pop
  ////////////////////////////////////////
  irq_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    irq_i |=> !irq_i)
    else $error("irq_o stayed high for two consecutive cycles");

  pop_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
    frame_read_i |-> wbs_ack_i)
    else $error("frame_read occurred without an ack in the same cycle");

endmodule

// File: verification/nec_ir_receiver_tb.sv
// Table-driven testbench sending NEC frames and checking status over Wishbone
`timescale 1ns/1ps

module nec_ir_receiver_tb;

  localparam int clk_half     = 4;    // 8 ns period
  localparam int unit_clocks  = 32;   // 8 ticks of 4 clocks
  localparam int gap_units    = 264;  // Long enough to saturate the edge timer
  localparam int seed         = 69787;
  localparam int ack_timeout  = 16;
  localparam int poll_limit   = 50;
  localparam int fifo_entries = 4;
  localparam int num_rows     = 6;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic        wbs_we_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic [31:0] wbs_dat_o;
  logic        wbs_ack_o;
  logic        ir_i;
  logic        irq_o;
  int          irq_total = 0;

  ////////////////////////////////////////
  // Test table
  ////////////////////////////////////////
  string      row_name      [num_rows];
  logic       row_pol       [num_rows];
  logic       row_irq       [num_rows];
  logic       row_en        [num_rows];
  logic [7:0] row_addr      [num_rows];
  logic [7:0] row_data      [num_rows];
  logic       row_corrupt   [num_rows];
  int         row_frames    [num_rows];
  logic       row_exp_avail [num_rows];
  logic [7:0] row_exp_addr  [num_rows];
  logic [7:0] row_exp_data  [num_rows];
  logic       row_exp_lost  [num_rows];

  nec_ir_receiver dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .ir_i      (ir_i),
    .irq_o     (irq_o)
  );

  bind nec_ir_receiver nec_ir_receiver_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .wbs_cyc_i    (wbs_cyc_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_ack_i    (wbs_ack_o),
    .irq_i        (irq_o),
    .frame_read_i (frame_read)
  );

  always #clk_half clk = ~clk;

  always @(negedge clk) begin
    if (rst_n && irq_o) irq_total <= irq_total + 1;  // Count irq pulses
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual) else
      report_failure($sformatf("error: %s %s expected %0h actual %0h",
                               name, field, expected, actual));
  endtask

  task automatic fill_row(input int idx, input string name, input logic pol,
                          input logic irq, input logic en, input logic corrupt,
                          input int frames, input logic exp_avail, input logic exp_lost);
    logic [7:0] a;
    logic [7:0] d;
    a = $urandom % 256;
    d = $urandom % 256;
    row_name[idx]      = name;
    row_pol[idx]       = pol;
    row_irq[idx]       = irq;
    row_en[idx]        = en;
    row_addr[idx]      = a;
    row_data[idx]      = d;
    row_corrupt[idx]   = corrupt;
    row_frames[idx]    = frames;
    row_exp_avail[idx] = exp_avail;
    row_exp_addr[idx]  = a;    // First frame read back unchanged
    row_exp_data[idx]  = d;
    row_exp_lost[idx]  = exp_lost;
  endtask

  // One Wishbone request with read data sampled on the falling edge
  task automatic bus_access(input logic we, input logic [1:0] sel,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= 1'b1;
    wbs_we_i  <= we;
    wbs_adr_i <= {28'd0, sel, 2'b00};
    wbs_dat_i <= wdata;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!wbs_ack_o && waited < ack_timeout);
    assert (wbs_ack_o) else report_failure("timeout waiting for the bus acknowledge");
    rdata = wbs_dat_o;
    @(posedge clk);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
    wbs_we_i  <= 1'b0;
  endtask

  // Mark is high before the optional inversion
  task automatic drive_level(input logic level, input logic pol, input int units);
    ir_i <= level ^ pol;
    repeat (units * unit_clocks) @(posedge clk);
  endtask

  task automatic send_frame(input logic pol, input logic [7:0] addr,
                            input logic [7:0] data, input logic corrupt);
    logic [31:0] payload;
    payload = {corrupt ? ~data ^ 8'h10 : ~data, data, ~addr, addr};  // Sent LSB first
    drive_level(1'b1, pol, 16);  // Leader mark
    drive_level(1'b0, pol, 8);
    for (int i = 0; i < 32; i++) begin
      drive_level(1'b1, pol, 1);
      drive_level(1'b0, pol, payload[i] ? 3 : 1);
    end
    drive_level(1'b1, pol, 1);   // Stop mark
    drive_level(1'b0, pol, gap_units);
  endtask

  task automatic run_row(input int r);
    logic [31:0] ctrl_word;
    logic [31:0] rd;
    logic [31:0] status;
    logic [7:0]  exp_a;
    logic [7:0]  exp_d;
    int          irq_start;
    int          irq_seen;
    int          polls;
    int          reads;
    bus_access(1'b1, nec_ir_pkg::ctrl_reg, 32'd0, rd);  // Disable clears the pipeline
    ir_i <= row_pol[r];                                  // Idle level at the pin
    repeat (64) @(posedge clk);
    ctrl_word = '0;
    ctrl_word[nec_ir_pkg::ctrl_en_bit]     = row_en[r];
    ctrl_word[nec_ir_pkg::ctrl_irq_en_bit] = row_irq[r];
    ctrl_word[nec_ir_pkg::ctrl_pol_bit]    = row_pol[r];
    bus_access(1'b1, nec_ir_pkg::ctrl_reg, ctrl_word, rd);
    bus_access(1'b0, nec_ir_pkg::ctrl_reg, 32'd0, rd);
    check_value(row_name[r], "control", ctrl_word, rd);
    irq_start = irq_total;
    for (int k = 0; k < row_frames[r]; k++) begin
      send_frame(row_pol[r], row_addr[r] + k[7:0], row_data[r] + k[7:0], row_corrupt[r]);
    end
    reads = row_exp_avail[r] ? ((row_frames[r] > fifo_entries) ? fifo_entries : row_frames[r])
                             : 0;
    polls = 0;
    do begin
      bus_access(1'b0, nec_ir_pkg::status_reg, 32'd0, status);
      polls++;
    end while (reads > 0 && !status[31] && polls < poll_limit);
    assert (reads == 0 || status[31]) else
      report_failure($sformatf("timeout waiting for a frame in test %s", row_name[r]));
    irq_seen = irq_total - irq_start;
    assert (row_irq[r] ? irq_seen > 0 : irq_seen == 0) else
      report_failure($sformatf("error: %s irq pulses expected %s actual %0d",
                               row_name[r], row_irq[r] ? "at least 1" : "0", irq_seen));
    for (int k = 0; k < reads; k++) begin
      if (k > 0) begin
        bus_access(1'b0, nec_ir_pkg::status_reg, 32'd0, status);
        check_value(row_name[r], "available", 1'b1, status[31]);
      end
      exp_a = row_exp_addr[r] + k[7:0];
      exp_d = row_exp_data[r] + k[7:0];
      check_value(row_name[r], "address", exp_a, status[15:8]);
      check_value(row_name[r], "data", exp_d, status[7:0]);
      check_value(row_name[r], "lost", (k == 0) ? row_exp_lost[r] : 1'b0, status[29]);
    end
    if (reads > 0) bus_access(1'b0, nec_ir_pkg::status_reg, 32'd0, status);
    check_value(row_name[r], "final available", 1'b0, status[31]);
    check_value(row_name[r], "final lost", (reads == 0) ? row_exp_lost[r] : 1'b0, status[29]);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    rst_n     = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    ir_i      = 1'b0;
    void'($urandom(seed));
    //       idx name                 pol   irq   en    bad   n  avail lost
    fill_row(0, "basic_frame",       1'b0, 1'b0, 1'b1, 1'b0, 1, 1'b1, 1'b0);
    fill_row(1, "bad_complement",    1'b0, 1'b0, 1'b1, 1'b1, 1, 1'b0, 1'b0);
    fill_row(2, "inverted_polarity", 1'b1, 1'b0, 1'b1, 1'b0, 1, 1'b1, 1'b0);
    fill_row(3, "fifo_overflow",     1'b0, 1'b0, 1'b1, 1'b0, 5, 1'b1, 1'b1);
    fill_row(4, "irq_enabled",       1'b0, 1'b1, 1'b1, 1'b0, 1, 1'b1, 1'b0);
    fill_row(5, "receiver_disabled", 1'b0, 1'b0, 1'b0, 1'b0, 1, 1'b0, 1'b0);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    bus_access(1'b1, nec_ir_pkg::mult_reg, 32'd1, rd);  // One tick every 4 clocks
    bus_access(1'b1, nec_ir_pkg::div_reg, 32'd4, rd);
    bus_access(1'b0, nec_ir_pkg::mult_reg, 32'd0, rd);
    check_value("setup", "multiplier", 32'd1, rd);
    bus_access(1'b0, nec_ir_pkg::div_reg, 32'd0, rd);
    check_value("setup", "divider", 32'd4, rd);
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule
